// ==== all.f ====
+incdir+.
tnn_pkg.sv
tnn_hidden_layer.sv
tnn_output_layer.sv
argmax.sv
cardio_tnn_classifier.sv
tb_cardio_tnn_classifier.sv

// ==== argmax.sv ====
`include "tnn_defines.svh"

module argmax (
    input  tnn_pkg::scores_t scores,
    output tnn_pkg::class_e  prediction
);

    // Unpack the struct so classes can be walked by index
    tnn_pkg::score_t score_arr [`TNN_CLASS_CNT];

    assign score_arr[tnn_pkg::CLASS_NORMAL]     = scores.normal;
    assign score_arr[tnn_pkg::CLASS_SUSPECT]    = scores.suspect;
    assign score_arr[tnn_pkg::CLASS_PATHOLOGIC] = scores.pathologic;

    always_comb begin
        tnn_pkg::score_t best;

        best       = score_arr[0];
        prediction = tnn_pkg::CLASS_NORMAL;

        // Strict compare keeps the lower index on a tie
        for (int c = 1; c < `TNN_CLASS_CNT; c++) begin
            if (score_arr[c] > best) begin
                best       = score_arr[c];
                prediction = tnn_pkg::class_e'(`TNN_CLASS_BITS'(c));
            end
        end
    end

endmodule

// ==== cardio_testdata.txt ====
// Columns: features[75:0] | pathologic, suspect, normal scores (6 bits each) | class (2 bits)
// All zero inputs give a three-way tie at 9, so class 0 wins
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924
000000000000000000024924

// ==== cardio_tnn_classifier.sv ====
module cardio_tnn_classifier (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  tnn_pkg::feature_vec_t features,
    output logic                  out_valid,
    output tnn_pkg::result_t      result
);

    tnn_pkg::hidden_t hidden_d;
    tnn_pkg::hidden_t hidden_q;
    logic             hidden_valid;
    tnn_pkg::scores_t scores;
    tnn_pkg::class_e  prediction;

    // ####################################################################
    // Stage 1 with the ternary hidden layer
    // ####################################################################

    tnn_hidden_layer i_hidden_layer (
        .features (features),
        .hidden   (hidden_d)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            hidden_valid <= 1'b0;
        end else begin
            hidden_valid <= in_valid;
        end
    end

    // Payload only moves with a sample
    always_ff @(posedge clk) begin
        if (in_valid) begin
            hidden_q <= hidden_d;
        end
    end

    // ####################################################################
    // Stage 2 with class scores and argmax
    // ####################################################################

    tnn_output_layer i_output_layer (
        .hidden (hidden_q),
        .scores (scores)
    );

    argmax i_argmax (
        .scores     (scores),
        .prediction (prediction)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= hidden_valid;
        end
    end

    // Result holds between samples and a dropped sample never lands
    always_ff @(posedge clk) begin
        if (hidden_valid && !reset) begin
            result.scores     <= scores;
            result.prediction <= prediction;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the classifier testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_cardio_tnn_classifier

verilator --binary -j 0 -f all.f --top-module "$TOP" -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$("./obj_dir/V$TOP")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "** PASS **"; then
    exit 0
fi

echo "Pass message not found"
exit 1

// ==== tb_cardio_tnn_classifier.sv ====
module tb_cardio_tnn_classifier;

    localparam int REC_CNT     = 40;
    localparam int REC_BITS    = 96;
    localparam int CYCLE_LIMIT = REC_CNT * 2 + 100;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    tnn_pkg::feature_vec_t features;
    logic                  out_valid;
    tnn_pkg::result_t      result;

    logic [REC_BITS-1:0] rec_mem [REC_CNT];

    tnn_pkg::result_t exp_q [$];
    int               due_q [$];

    tnn_pkg::result_t last_result;
    logic             have_last;
    logic [31:0]      lfsr;
    int               cycle;
    int               clk_count;
    int               value_errors;
    int               protocol_errors;

    cardio_tnn_classifier i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .features  (features),
        .out_valid (out_valid),
        .result    (result)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ####################################################################
    // Helpers
    // ####################################################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // Highest score wins and the lower index takes a tie
    function automatic tnn_pkg::class_e expected_class(input tnn_pkg::scores_t s);
        tnn_pkg::class_e c;
        tnn_pkg::score_t best;
        c    = tnn_pkg::CLASS_NORMAL;
        best = s.normal;
        if (s.suspect > best) begin
            c    = tnn_pkg::CLASS_SUSPECT;
            best = s.suspect;
        end
        if (s.pathologic > best) begin
            c = tnn_pkg::CLASS_PATHOLOGIC;
        end
        return c;
    endfunction

    task automatic check_scores(input tnn_pkg::scores_t got, input tnn_pkg::scores_t exp);
        if (got !== exp) begin
            $display("FAIL result.scores got %h expected %h", got, exp);
            value_errors++;
        end
    endtask

    task automatic check_class(input tnn_pkg::class_e got, input tnn_pkg::class_e exp);
        if (got !== exp) begin
            $display("FAIL result.prediction got %h expected %h", got, exp);
            value_errors++;
        end
    endtask

    task automatic check_outputs();
        tnn_pkg::result_t exp;
        int               due;
        // Results that should already have appeared
        while (exp_q.size() > 0 && due_q[0] < cycle) begin
            $display("Result missing for the sample due in cycle %0d", due_q[0]);
            protocol_errors++;
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Extra out_valid in cycle %0d with no sample in flight", cycle);
                protocol_errors++;
            end else begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                if (due != cycle) begin
                    $display("Result came in cycle %0d but was due in cycle %0d", cycle, due);
                    protocol_errors++;
                end
                check_scores(result.scores, exp.scores);
                check_class(result.prediction, exp.prediction);
            end
            last_result = result;
            have_last   = 1'b1;
        end else if (out_valid !== 1'b0) begin
            $display("out_valid is unknown in cycle %0d", cycle);
            protocol_errors++;
        end else if (have_last && result !== last_result) begin
            $display("FAIL result got %h expected %h", result, last_result);
            value_errors++;
        end
    endtask

    // One clock cycle that checks outputs and then drives the next inputs
    task automatic step(input logic valid, input int idx, input logic rst);
        tnn_pkg::result_t exp;
        @(negedge clk);
        cycle++;
        check_outputs();
        reset    = rst;
        in_valid = valid;
        features = valid ? rec_mem[idx][95:20] : '0;
        if (rst) begin
            exp_q.delete();
            due_q.delete();
        end else if (valid) begin
            exp.scores     = rec_mem[idx][19:2];
            exp.prediction = tnn_pkg::class_e'(rec_mem[idx][1:0]);
            if (expected_class(exp.scores) !== exp.prediction) begin
                $display("Data file class disagrees with its scores in record %0d", idx);
                protocol_errors++;
                exp.prediction = expected_class(exp.scores);
            end
            exp_q.push_back(exp);
            due_q.push_back(cycle + 2);
        end
    endtask

    // ####################################################################
    // Run limit
    // ####################################################################

    always @(posedge clk) begin
        clk_count++;
        if (clk_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", clk_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // ####################################################################
    // Stimulus
    // ####################################################################

    initial begin
        reset           = 1'b1;
        in_valid        = 1'b0;
        features        = '0;
        have_last       = 1'b0;
        last_result     = '0;
        lfsr            = 32'h936b;
        cycle           = 0;
        clk_count       = 0;
        value_errors    = 0;
        protocol_errors = 0;
        $readmemh("cardio_testdata.txt", rec_mem);
        if ($isunknown(rec_mem[REC_CNT-1])) begin
            $display("Data file did not load all %0d records", REC_CNT);
            protocol_errors++;
        end

        repeat (16) @(negedge clk);
        reset = 1'b0;

        // Quiet pipeline after reset
        repeat (4) step(1'b0, 0, 1'b0);

        // Back to back
        for (int i = 0; i < REC_CNT; i++) begin
            step(1'b1, i, 1'b0);
        end

        // Random idle gaps
        for (int i = 0; i < REC_CNT; i++) begin
            lfsr = lfsr_next(lfsr);
            if (lfsr[0]) begin
                step(1'b0, 0, 1'b0);
            end
            step(1'b1, i, 1'b0);
        end

        // Reset with samples in flight
        for (int i = 0; i < 5; i++) begin
            step(1'b1, i, 1'b0);
        end
        repeat (3) step(1'b0, 0, 1'b1);
        for (int i = 5; i < 8; i++) begin
            step(1'b1, i, 1'b0);
        end
        repeat (6) step(1'b0, 0, 1'b0);

        if (exp_q.size() > 0) begin
            $display("%0d results never appeared", exp_q.size());
            protocol_errors += exp_q.size();
        end

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tnn_defines.svh ====
`ifndef TNN_DEFINES_SVH
`define TNN_DEFINES_SVH

// ####################################################################
// Network dimensions
// ####################################################################

// Features per cardiotocography record
`define TNN_FEAT_CNT 19

// Each feature is a 4-bit unsigned value
`define TNN_FEAT_BITS 4

// Hidden neurons in the ternary layer
`define TNN_HIDDEN_CNT 40

// Normal, suspect and pathologic
`define TNN_CLASS_CNT 3

// Class score holds a count from 0 to 40
`define TNN_SCORE_BITS 6

// Class label width
`define TNN_CLASS_BITS 2

`endif

// ==== tnn_hidden_layer.sv ====
`include "tnn_defines.svh"

module tnn_hidden_layer (
    input  tnn_pkg::feature_vec_t features,
    output tnn_pkg::hidden_t      hidden
);

    // Signed width that holds +/- the sum of all features
    localparam int NODE_BITS = `TNN_FEAT_BITS + $clog2(`TNN_FEAT_CNT + 1) + 1;
    localparam int ADD_CNT   = 202;
    localparam int NODE_CNT  = 2 * `TNN_FEAT_CNT + ADD_CNT;
    localparam int IDX_BITS  = $clog2(NODE_CNT);

    // ####################################################################
    // Shared adder graph
    // ####################################################################

    // Entry i is two 16-bit node indices (low half first operand)
    // Its sum becomes node 2*FEAT_CNT + i, entry 0 in the low bits
    localparam logic [ADD_CNT*32-1:0] ADD_PAIRS = {
        256'h00b500d3_00a200cb_00b600c9_009500c7_00a800c5_009600c4_009200c3_008300c2,
        256'h008a00c1_00a300c0_00a500bf_008000be_008800bd_00af00bc_008400bb_009100b8,
        256'h009b00b7_008200b4_008500b3_009d00b2_00a100b1_007f00b0_007a00ae_006400ad,
        256'h007700ac_006300ab_008f00aa_008900a9_008700a7_005c00a6_007900a4_005800a0,
        256'h008e009f_0072009e_007d009c_0086009a_007e0099_00730098_008d0097_00670094,
        256'h007c0093_005d0090_0078008c_0054008b_00610081_005e007b_00510076_00540075,
        256'h00510074_00650071_004f0070_0059006f_0055006e_0030006d_002e006c_005c006b,
        256'h005a006a_004b0069_005b0068_00590066_00470062_005b0060_004f005f_004e005a,
        256'h00520058_00330057_002c0057_00490056_00120056_00480055_004a0053_00400053,
        256'h003d0052_0024004e_003f004d_0039004d_004b004c_0045004c_0048004a_00310049,
        256'h00440047_00380046_00170046_003d0045_00420044_00400043_003a0043_00310042,
        256'h00390041_00380041_003d003f_001a003e_0035003c_0036003b_00220039_002d0037,
        256'h00300036_00300035_002c0035_00290035_00310033_00300033_001b0033_002c0032,
        256'h00230032_00210032_002b0031_00260031_002a0030_001c002f_002d002e_002b002e,
        256'h002a002d_0028002c_0007002b_0019002a_00200029_00250028_00190028_00240027,
        256'h00130023_00120023_001f0021_00150021_0008001f_0005001f_0017001d_000d001d,
        256'h0002001d_0007001b_0001001a_000a0019_00150018_000e0018_00140017_00150016,
        256'h00000016_000f0011_00050011_000a0010_00020010_000b000f_0000000c_0009000a,
        256'h00040009_00000008_00020004_00340050_000c003e_000f003c_0001003b_0019003a,
        256'h00070038_00290036_00320034_000d002f_000b002f_000b002e_001e002c_001c002a,
        256'h0012002a_00060028_00100027_00240025_00220023_00180021_00110021_0000001b,
        256'h0010001a_0008001a_00150017_000c0014_000b0014_00030013_000e0011_00060008,
        256'h00040008_00200037_001d002d_00090023_00050021_000d001c_000a001b_0019002b,
        256'h00010028_00060026_00020020_000c001e_000f0015_00040029_001d0025_00110018,
        256'h00130017_00070008_00120024_0000001f_001c0027_001a0026_00090022_0005000e,
        64'h00010003_00140016
    };

    // Node holding each neuron's total, neuron 0 in the low bits
    localparam logic [`TNN_HIDDEN_CNT*16-1:0] OUT_NODE = {
        256'h00e900da_00cd00e4_00e700c8_00ee00d9_00ef00eb_00e600de_00dc00dd_00ca00d8,
        256'h00d400ba_00df00e2_00ec00d1_00ce00d2_00e000b9_00ea00d6_00cc00e1_00db00d0,
        128'h00e300d7_00d500ed_00e800e5_00cf00c6
    };

    // Nodes 0..18 are the features, 19..37 their negations, then the sums
    logic signed [NODE_BITS-1:0] node [NODE_CNT];

    always_comb begin
        logic [IDX_BITS-1:0] op_a;
        logic [IDX_BITS-1:0] op_b;

        for (int f = 0; f < `TNN_FEAT_CNT; f++) begin
            node[f]                 = signed'(NODE_BITS'(features[f]));
            node[`TNN_FEAT_CNT + f] = -signed'(NODE_BITS'(features[f]));
        end

        // Operands always index lower nodes, so one ordered pass settles the graph
        for (int a = 0; a < ADD_CNT; a++) begin
            op_a = ADD_PAIRS[a*32 +: IDX_BITS];
            op_b = ADD_PAIRS[a*32 + 16 +: IDX_BITS];
            node[2*`TNN_FEAT_CNT + a] = node[op_a] + node[op_b];
        end
    end

    // ####################################################################
    // Sign decision
    // ####################################################################

    // Neuron fires when its total is not negative
    for (genvar n = 0; n < `TNN_HIDDEN_CNT; n++) begin : g_neuron
        assign hidden[n] = ~node[OUT_NODE[n*16 +: IDX_BITS]][NODE_BITS-1];
    end

endmodule

// ==== tnn_output_layer.sv ====
`include "tnn_defines.svh"

module tnn_output_layer (
    input  tnn_pkg::hidden_t hidden,
    output tnn_pkg::scores_t scores
);

    localparam int HID = `TNN_HIDDEN_CNT;

    // ####################################################################
    // Binary weights and use mask
    // ####################################################################

    // Class c occupies bits [c*40 +: 40], neuron 0 in the low bit
    localparam logic [`TNN_CLASS_CNT*HID-1:0] WEIGHT = {
        // Pathologic
        40'b0100000010_0010000000_1000000010_0010110100,
        // Suspect
        40'b0000000000_0110000000_0000100100_1011100010,
        // Normal
        40'b0011000100_0111010000_0010000000_0000000010
    };

    // Connections that survived pruning
    localparam logic [`TNN_CLASS_CNT*HID-1:0] USE = {
        40'b0100001010_0010000000_1000101010_0110110100,
        40'b0010001001_0110000000_0000100100_1011100110,
        40'b0011001100_0111010000_0010000101_0000001010
    };

    tnn_pkg::score_t count [`TNN_CLASS_CNT];

    // Popcount of used neurons that agree with their weight
    always_comb begin
        for (int c = 0; c < `TNN_CLASS_CNT; c++) begin
            count[c] = '0;
            for (int n = 0; n < HID; n++) begin
                if (USE[c*HID + n] && (hidden[n] == WEIGHT[c*HID + n])) begin
                    count[c] = count[c] + `TNN_SCORE_BITS'(1);
                end
            end
        end
    end

    assign scores.normal     = count[tnn_pkg::CLASS_NORMAL];
    assign scores.suspect    = count[tnn_pkg::CLASS_SUSPECT];
    assign scores.pathologic = count[tnn_pkg::CLASS_PATHOLOGIC];

endmodule

// ==== tnn_pkg.sv ====
`include "tnn_defines.svh"

package tnn_pkg;

    // ################################################################
    // Data types shared by the classifier
    // ################################################################

    // Feature 0 sits in the low bits
    typedef logic [`TNN_FEAT_CNT-1:0][`TNN_FEAT_BITS-1:0] feature_vec_t;

    // One sign bit per hidden neuron
    typedef logic [`TNN_HIDDEN_CNT-1:0] hidden_t;

    // Count of agreeing neurons for one class
    typedef logic [`TNN_SCORE_BITS-1:0] score_t;

    // Normal lands in the low bits so class i sits at bits i*6
    typedef struct packed {
        score_t pathologic;
        score_t suspect;
        score_t normal;
    } scores_t;

    // Class label whose encoding is fixed by the training flow
    typedef enum logic [`TNN_CLASS_BITS-1:0] {
        CLASS_NORMAL     = 2'd0,
        CLASS_SUSPECT    = 2'd1,
        CLASS_PATHOLOGIC = 2'd2
    } class_e;

    // What leaves the pipeline for each sample
    typedef struct packed {
        scores_t scores;
        class_e  prediction;
    } result_t;

endpackage
